// ==== vlog.f ====
+incdir+include
verilog/robot_pkg.sv
verilog/target_finder.sv
verilog/frame_classifier.sv
verilog/sensor_driver.sv
verilog/drive_fsm.sv
verilog/vision_robot_top.sv
tests/tb_vision_robot.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the robot testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vlog.f --top-module tb_vision_robot
./obj_dir/Vtb_vision_robot > sim.log 2>&1 || true
cat sim.log
if grep -qx "sim passed" sim.log; then
  exit 0
fi
exit 1

// ==== tests/tb_vision_robot.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "robot_settings.svh"

module tb_vision_robot;
  import robot_pkg::*;

  // Tests need about 5200 cycles
  // Three ranger timeouts would still fit inside this limit
  localparam int RUN_LIMIT = 20000;
  // Monitor colour for a detected pixel
  localparam rgb_t HIGHLIGHT = '{red: 8'd0, green: 8'd255, blue: 8'd0};
  localparam rgb_t ORANGE = '{red: 8'd200, green: 8'd100, blue: 8'd40};
  localparam rgb_t GREY = '{red: 8'd60, green: 8'd60, blue: 8'd60};

  logic        clk_50;
  logic        reset;
  video_beat_t video_in;
  logic [7:0]  ir_button;
  logic        ir_valid;
  logic        measure;
  logic        echo;
  video_beat_t video_out;
  logic        trig;
  direction_t  direction;
  logic        orange_detected;
  logic [15:0] distance_cm;
  drive_cmd_t  drive_cmd;
  logic        auto_mode;

  int          cycle_count = 0;
  logic [31:0] lfsr_state;

  vision_robot_top dut_i (
    .clk_50          (clk_50),
    .reset           (reset),
    .video_in        (video_in),
    .ir_button       (ir_button),
    .ir_valid        (ir_valid),
    .measure         (measure),
    .echo            (echo),
    .video_out       (video_out),
    .trig            (trig),
    .direction       (direction),
    .orange_detected (orange_detected),
    .distance_cm     (distance_cm),
    .drive_cmd       (drive_cmd),
    .auto_mode       (auto_mode)
  );

  // 100 ns clock period
  initial clk_50 = 1'b0;
  always #50 clk_50 = ~clk_50;

  // Run watchdog
  always @(posedge clk_50) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == RUN_LIMIT) begin
      $display("run stopped at the cycle limit of %0d", RUN_LIMIT);
      $display("sim failed");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s expected %0h actual %0h", test_name, expected, actual);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1, "%s", what);
  endtask

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return (state >> 1) ^ (state[0] ? 32'h80200003 : 32'h0);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] random_value(input int nbits);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // Channels kept near the orange window, so hits and misses both occur
  function automatic rgb_t random_pixel();
    rgb_t px;
    px.red   = 8'd128 + 8'(random_value(7));
    px.green = 8'd32 + 8'(random_value(7));
    px.blue  = 8'(random_value(7));
    return px;
  endfunction

  // Reference marking rule
  function automatic video_beat_t expected_mark(input video_beat_t b);
    video_beat_t m;
    m = b;
    if (b.valid && (b.rgb.red >= 8'(`ORANGE_R_MIN)) && (b.rgb.green >= 8'(`ORANGE_G_MIN)) &&
        (b.rgb.green <= 8'(`ORANGE_G_MAX)) && (b.rgb.blue <= 8'(`ORANGE_B_MAX))) begin
      m.rgb = HIGHLIGHT;
    end
    return m;
  endfunction

  function automatic int largest_count(input int l, input int c, input int r);
    int most;
    most = (l > c) ? l : c;
    most = (r > most) ? r : most;
    return most;
  endfunction

  // Biggest zone wins, centre then left on a tie
  function automatic direction_t expected_direction(input int l, input int c, input int r);
    int most;
    most = largest_count(l, c, r);
    if (c == most) begin
      return dir_straight;
    end else if (l == most) begin
      return dir_left;
    end
    return dir_right;
  endfunction

  function automatic logic expected_found(input int l, input int c, input int r);
    return largest_count(l, c, r) >= `ORANGE_MIN_COUNT;
  endfunction

  task automatic drive_beat(input video_beat_t b);
    video_in = b;
    @(negedge clk_50);
  endtask

  // Four lines, orange pixels of a zone filled line by line from its left edge
  task automatic send_frame(input int n_left, input int n_centre, input int n_right);
    video_beat_t b;
    int zone_w;
    int zone;
    int offset;
    int quota;
    zone_w = `FRAME_WIDTH / 3;
    for (int ln = 0; ln < 4; ln++) begin
      for (int c = 0; c < `FRAME_WIDTH; c++) begin
        zone   = c / zone_w;
        offset = ln * zone_w + c % zone_w;
        quota  = (zone == 0) ? n_left : ((zone == 1) ? n_centre : n_right);
        b       = '0;
        b.valid = 1'b1;
        b.sol   = (c == 0);
        b.rgb   = (offset < quota) ? ORANGE : GREY;
        drive_beat(b);
      end
      // Horizontal blanking
      drive_beat('0);
    end
    b     = '0;
    b.eof = 1'b1;
    drive_beat(b);
    video_in = '0;
  endtask

  task automatic wait_result();
    int n;
    n = 0;
    while (dut_i.frame_classifier_i.result_valid !== 1'b1) begin
      if (n == 8) begin
        stop_with_error("no frame result after the end of frame");
      end else begin
        @(negedge clk_50);
        n++;
      end
    end
  endtask

  task automatic check_frame(input string name, input int l, input int c, input int r);
    send_frame(l, c, r);
    wait_result();
    check_value(name, 32'(expected_direction(l, c, r)), 32'(direction));
    check_value(name, 32'(expected_found(l, c, r)), 32'(orange_detected));
  endtask

  // Measure pulse, trigger width, optional echo, then the distance result
  task automatic range_once(input string name, input int echo_cycles);
    int n;
    measure = 1'b1;
    @(negedge clk_50);
    measure = 1'b0;
    for (int i = 0; i < `TRIG_CYCLES; i++) begin
      check_value(name, 32'd1, 32'(trig));
      @(negedge clk_50);
    end
    check_value(name, 32'd0, 32'(trig));
    if (echo_cycles > 0) begin
      // Sound travel time before the echo rises
      repeat (12) @(negedge clk_50);
      echo = 1'b1;
      repeat (echo_cycles) @(negedge clk_50);
      echo = 1'b0;
    end
    n = 0;
    while (dut_i.sensor_driver_i.distance_valid !== 1'b1) begin
      if (n == `ECHO_TIMEOUT + 16) begin
        stop_with_error("ranger gave no distance result");
      end else begin
        @(negedge clk_50);
        n++;
      end
    end
    if (echo_cycles > 0) begin
      check_value(name, 32'(echo_cycles / `CYCLES_PER_CM), 32'(distance_cm));
    end else begin
      check_value(name, 32'hffff, 32'(distance_cm));
    end
  endtask

  // Command is due one cycle after the strobe
  task automatic press_button(input string name, input logic [7:0] code,
                              input drive_cmd_t expected);
    ir_button = code;
    ir_valid  = 1'b1;
    @(negedge clk_50);
    ir_valid = 1'b0;
    check_value(name, 32'(expected), 32'(drive_cmd));
  endtask

  task automatic steer_frame(input string name, input int l, input int c, input int r);
    drive_cmd_t expected;
    if (!expected_found(l, c, r)) begin
      expected = cmd_stop;
    end else begin
      case (expected_direction(l, c, r))
        dir_left:  expected = cmd_left;
        dir_right: expected = cmd_right;
        default:   expected = cmd_forward;
      endcase
    end
    send_frame(l, c, r);
    // One edge has passed since eof, the command lands on the third
    repeat (2) @(negedge clk_50);
    check_value(name, 32'(expected), 32'(drive_cmd));
  endtask

  task automatic test_reset_state();
    check_value("reset_state", 32'(cmd_stop), 32'(drive_cmd));
    check_value("reset_state", 32'd0, 32'(auto_mode));
    check_value("reset_state", 32'd0, 32'(trig));
    check_value("reset_state", 32'hffff, 32'(distance_cm));
    check_value("reset_state", 32'(dir_straight), 32'(direction));
    check_value("reset_state", 32'd0, 32'(orange_detected));
    check_value("reset_state", 32'd0, 32'({video_out.valid, video_out.eof}));
  endtask

  task automatic test_pixel_marking();
    video_beat_t beats[$];
    video_beat_t b;
    rgb_t        edge_px[8];
    // Just inside and just outside each threshold
    edge_px = '{'{8'd160, 8'd60, 8'd80}, '{8'd159, 8'd60, 8'd80}, '{8'd160, 8'd59, 8'd80},
                '{8'd160, 8'd150, 8'd80}, '{8'd160, 8'd151, 8'd80}, '{8'd200, 8'd100, 8'd81},
                '{8'd255, 8'd150, 8'd0}, '{8'd255, 8'd255, 8'd255}};
    for (int ln = 0; ln < 2; ln++) begin
      for (int c = 0; c < `FRAME_WIDTH; c++) begin
        b       = '0;
        b.valid = 1'b1;
        b.sol   = (c == 0);
        b.rgb   = ((ln == 0) && (c < 8)) ? edge_px[c] : random_pixel();
        beats.push_back(b);
      end
      // Blank beat with an orange colour passes unmarked
      b     = '0;
      b.rgb = ORANGE;
      beats.push_back(b);
    end
    b     = '0;
    b.eof = 1'b1;
    beats.push_back(b);
    foreach (beats[i]) begin
      drive_beat(beats[i]);
      check_value("pixel_marking", 32'(expected_mark(beats[i])), 32'(video_out));
    end
    video_in = '0;
    @(negedge clk_50);
  endtask

  task automatic test_frame_classification();
    check_frame("frame_left", 10, 2, 1);
    check_frame("frame_right", 1, 3, 12);
    check_frame("frame_centre", 0, 20, 5);
    check_frame("frame_tie_left_right", 7, 3, 7);
    check_frame("frame_tie_left_centre", 6, 6, 2);
    check_frame("frame_too_few", 2, 1, 3);
  endtask

  task automatic test_ranging();
    range_once("ranging_echo", 200);
    range_once("ranging_no_echo", 0);
  endtask

  task automatic test_manual_control();
    press_button("manual_fwd", `IR_FWD, cmd_forward);
    press_button("manual_rev", `IR_REV, cmd_reverse);
    press_button("manual_left", `IR_LEFT, cmd_left);
    press_button("manual_right", `IR_RIGHT, cmd_right);
    // Unknown code leaves the running command alone
    press_button("manual_unknown", 8'h77, cmd_right);
    press_button("manual_stop", `IR_STOP, cmd_stop);
    press_button("manual_fwd_again", `IR_FWD, cmd_forward);
    // Near reading stops a running forward
    range_once("obstacle_near", 80);
    @(negedge clk_50);
    check_value("obstacle_stop", 32'(cmd_stop), 32'(drive_cmd));
    press_button("obstacle_fwd", `IR_FWD, cmd_stop);
    press_button("obstacle_left", `IR_LEFT, cmd_left);
    range_once("obstacle_far", 400);
    press_button("clear_fwd", `IR_FWD, cmd_forward);
  endtask

  task automatic test_auto_steering();
    press_button("auto_enter", `IR_AUTO, cmd_forward);
    check_value("auto_enter", 32'd1, 32'(auto_mode));
    steer_frame("auto_left", 12, 1, 0);
    steer_frame("auto_right", 0, 2, 9);
    steer_frame("auto_forward", 1, 15, 1);
    steer_frame("auto_no_target", 1, 1, 2);
    steer_frame("auto_forward_again", 3, 20, 2);
    check_value("auto_hold", 32'd1, 32'(auto_mode));
  endtask

  initial begin
    lfsr_state = 32'h3e2321d1;
    reset      = 1'b1;
    video_in   = '0;
    ir_button  = '0;
    ir_valid   = 1'b0;
    measure    = 1'b0;
    echo       = 1'b0;
    // Reset over 8 rising edges, released on a falling edge
    repeat (8) @(negedge clk_50);
    reset = 1'b0;
    test_reset_state();
    test_pixel_marking();
    test_frame_classification();
    test_ranging();
    test_manual_control();
    test_auto_steering();
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/vision_robot_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module vision_robot_top (
  input  wire logic                   clk_50,
  input  wire logic                   reset,
  input  wire robot_pkg::video_beat_t video_in,
  input  wire logic [7:0]             ir_button,
  input  wire logic                   ir_valid,
  input  wire logic                   measure,
  input  wire logic                   echo,
  output robot_pkg::video_beat_t      video_out,
  output logic                        trig,
  output robot_pkg::direction_t       direction,
  output logic                        orange_detected,
  output logic [15:0]                 distance_cm,
  output robot_pkg::drive_cmd_t       drive_cmd,
  output logic                        auto_mode
);
  import robot_pkg::*;

  // Marked stream, to the monitor and the classifier
  video_beat_t marked_beat;
  logic        is_orange;
  logic        result_valid;
  logic        distance_valid;

  assign video_out = marked_beat;

  // Colour test and recolouring, one cycle
  target_finder target_finder_i (
    .clk_50    (clk_50),
    .reset     (reset),
    .video_in  (video_in),
    .video_out (marked_beat),
    .is_orange (is_orange)
  );

  // Zone counts to steering direction at frame end
  frame_classifier frame_classifier_i (
    .clk_50          (clk_50),
    .reset           (reset),
    .beat            (marked_beat),
    .is_orange       (is_orange),
    .result_valid    (result_valid),
    .direction       (direction),
    .orange_detected (orange_detected)
  );

  // Ultrasonic ranger
  sensor_driver sensor_driver_i (
    .clk_50         (clk_50),
    .reset          (reset),
    .measure        (measure),
    .echo           (echo),
    .trig           (trig),
    .distance_valid (distance_valid),
    .distance_cm    (distance_cm)
  );

  drive_fsm drive_fsm_i (
    .clk_50          (clk_50),
    .reset           (reset),
    .ir_button       (ir_button),
    .ir_valid        (ir_valid),
    .result_valid    (result_valid),
    .direction       (direction),
    .orange_detected (orange_detected),
    .distance_valid  (distance_valid),
    .distance_cm     (distance_cm),
    .drive_cmd       (drive_cmd),
    .auto_mode       (auto_mode)
  );

endmodule

`default_nettype wire

// ==== verilog/drive_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "robot_settings.svh"

module drive_fsm (
  input  wire logic                  clk_50,
  input  wire logic                  reset,
  input  wire logic [7:0]            ir_button,
  input  wire logic                  ir_valid,
  input  wire logic                  result_valid,
  input  wire robot_pkg::direction_t direction,
  input  wire logic                  orange_detected,
  input  wire logic                  distance_valid,
  input  wire logic [15:0]           distance_cm,
  output robot_pkg::drive_cmd_t      drive_cmd,
  output logic                       auto_mode
);
  import robot_pkg::*;

  logic       too_close;
  logic       too_close_next;
  logic       ir_known;
  logic       auto_next;
  drive_cmd_t ir_cmd;
  drive_cmd_t vision_cmd;
  drive_cmd_t cmd_next;

  // IR decode, auto button keeps the current command
  always_comb begin
    ir_known = 1'b1;
    ir_cmd   = drive_cmd;
    case (ir_button)
      `IR_FWD:   ir_cmd = cmd_forward;
      `IR_REV:   ir_cmd = cmd_reverse;
      `IR_LEFT:  ir_cmd = cmd_left;
      `IR_RIGHT: ir_cmd = cmd_right;
      `IR_STOP:  ir_cmd = cmd_stop;
      `IR_AUTO:  ir_cmd = drive_cmd;
      default:   ir_known = 1'b0;
    endcase
  end

  // Camera steering, stop when no target is seen
  always_comb begin
    if (!orange_detected) begin
      vision_cmd = cmd_stop;
    end else begin
      case (direction)
        dir_left:  vision_cmd = cmd_left;
        dir_right: vision_cmd = cmd_right;
        default:   vision_cmd = cmd_forward;
      endcase
    end
  end

  // Next command
  // IR has priority over vision, obstacle check applies last
  always_comb begin
    too_close_next = too_close;
    if (distance_valid) begin
      too_close_next = distance_cm < 16'(`STOP_DISTANCE_CM);
    end
    auto_next = auto_mode;
    cmd_next  = drive_cmd;
    if (ir_valid && ir_known) begin
      auto_next = (ir_button == `IR_AUTO);
      cmd_next  = ir_cmd;
    end else if (auto_mode && result_valid) begin
      cmd_next = vision_cmd;
    end
    // Also stops a running forward when a near reading arrives
    if (too_close_next && (cmd_next == cmd_forward)) begin
      cmd_next = cmd_stop;
    end
  end

  always_ff @(posedge clk_50) begin
    if (reset) begin
      drive_cmd <= cmd_stop;
      auto_mode <= 1'b0;
      too_close <= 1'b0;
    end else begin
      drive_cmd <= cmd_next;
      auto_mode <= auto_next;
      too_close <= too_close_next;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/sensor_driver.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "robot_settings.svh"

module sensor_driver (
  input  wire logic   clk_50,
  input  wire logic   reset,
  input  wire logic   measure,
  input  wire logic   echo,
  output logic        trig,
  output logic        distance_valid,
  output logic [15:0] distance_cm
);

  // Prescaler counts echo cycles inside one centimetre
  localparam int PRE_W = $clog2(`CYCLES_PER_CM);

  typedef enum logic [1:0] {
    st_idle,
    st_trigger,
    st_wait_echo,
    st_timing
  } state_t;

  state_t           state;
  logic [15:0]      cycle_cnt;
  logic [15:0]      cm_cnt;
  logic [PRE_W-1:0] prescale;

  always_ff @(posedge clk_50) begin
    if (reset) begin
      state          <= st_idle;
      trig           <= 1'b0;
      distance_valid <= 1'b0;
      distance_cm    <= 16'hffff;
      cycle_cnt      <= '0;
      cm_cnt         <= '0;
      prescale       <= '0;
    end else begin
      distance_valid <= 1'b0;
      case (state)
        st_idle: begin
          // Measure while busy never reaches here
          if (measure) begin
            state     <= st_trigger;
            trig      <= 1'b1;
            cycle_cnt <= '0;
          end
        end
        st_trigger: begin
          cycle_cnt <= cycle_cnt + 16'd1;
          if (cycle_cnt == 16'(`TRIG_CYCLES - 1)) begin
            trig      <= 1'b0;
            cycle_cnt <= '0;
            state     <= st_wait_echo;
          end
        end
        st_wait_echo: begin
          if (echo) begin
            // First echo-high cycle already counts
            prescale <= PRE_W'(1);
            cm_cnt   <= '0;
            state    <= st_timing;
          end else if (cycle_cnt == 16'(`ECHO_TIMEOUT - 1)) begin
            // Nothing in range, report the far marker
            distance_valid <= 1'b1;
            distance_cm    <= 16'hffff;
            state          <= st_idle;
          end else begin
            cycle_cnt <= cycle_cnt + 16'd1;
          end
        end
        st_timing: begin
          if (echo) begin
            if (prescale == PRE_W'(`CYCLES_PER_CM - 1)) begin
              prescale <= '0;
              cm_cnt   <= cm_cnt + 16'd1;
            end else begin
              prescale <= prescale + PRE_W'(1);
            end
          end else begin
            // Echo fell, whole centimetres only
            distance_valid <= 1'b1;
            distance_cm    <= cm_cnt;
            state          <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Trigger pulse is confined to its own state
  assert property (@(posedge clk_50) disable iff (reset)
    trig |-> (state == st_trigger))
    else $error("trig outside trigger state");

endmodule

`default_nettype wire

// ==== verilog/frame_classifier.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "robot_settings.svh"

module frame_classifier (
  input  wire logic                   clk_50,
  input  wire logic                   reset,
  input  wire robot_pkg::video_beat_t beat,
  input  wire logic                   is_orange,
  output logic                        result_valid,
  output robot_pkg::direction_t       direction,
  output logic                        orange_detected
);
  import robot_pkg::*;

  // Column counter must also hold FRAME_WIDTH after the last pixel
  localparam int COL_W = $clog2(`FRAME_WIDTH + 1);
  // Zone borders, left third and right third
  localparam logic [COL_W-1:0] LEFT_END    = COL_W'(`FRAME_WIDTH / 3);
  localparam logic [COL_W-1:0] RIGHT_START = COL_W'(2 * `FRAME_WIDTH / 3);

  logic [COL_W-1:0] col;
  logic [COL_W-1:0] col_idx;
  logic [15:0]      cnt_left;
  logic [15:0]      cnt_centre;
  logic [15:0]      cnt_right;
  logic [15:0]      best_cnt;
  direction_t       best_dir;

  // Column of the current pixel, sol restarts the line
  assign col_idx = beat.sol ? '0 : col;

  // Largest zone wins
  // Ties go to centre first, then left
  always_comb begin
    if ((cnt_centre >= cnt_left) && (cnt_centre >= cnt_right)) begin
      best_dir = dir_straight;
      best_cnt = cnt_centre;
    end else if (cnt_left >= cnt_right) begin
      best_dir = dir_left;
      best_cnt = cnt_left;
    end else begin
      best_dir = dir_right;
      best_cnt = cnt_right;
    end
  end

  always_ff @(posedge clk_50) begin
    if (reset) begin
      col             <= '0;
      cnt_left        <= '0;
      cnt_centre      <= '0;
      cnt_right       <= '0;
      result_valid    <= 1'b0;
      direction       <= dir_straight;
      orange_detected <= 1'b0;
    end else begin
      result_valid <= 1'b0;
      if (beat.valid) begin
        col <= col_idx + COL_W'(1);
      end
      if (beat.eof) begin
        // Publish the frame result, hold it until the next frame
        result_valid    <= 1'b1;
        direction       <= best_dir;
        orange_detected <= best_cnt >= 16'(`ORANGE_MIN_COUNT);
        col             <= '0;
        cnt_left        <= '0;
        cnt_centre      <= '0;
        cnt_right       <= '0;
      end else if (beat.valid && is_orange) begin
        // Bin the target pixel by column
        if (col_idx < LEFT_END) begin
          cnt_left <= cnt_left + 16'd1;
        end else if (col_idx >= RIGHT_START) begin
          cnt_right <= cnt_right + 16'd1;
        end else begin
          cnt_centre <= cnt_centre + 16'd1;
        end
      end
    end
  end

  // Lines longer than the frame width would skew the zones
  assert property (@(posedge clk_50) disable iff (reset)
    beat.valid |-> (col_idx < COL_W'(`FRAME_WIDTH)))
    else $error("column past frame width");

endmodule

`default_nettype wire

// ==== verilog/target_finder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "robot_settings.svh"

module target_finder (
  input  wire logic                   clk_50,
  input  wire logic                   reset,
  input  wire robot_pkg::video_beat_t video_in,
  output robot_pkg::video_beat_t      video_out,
  output logic                        is_orange
);
  import robot_pkg::*;

  // Colour painted over target pixels on the monitor
  localparam rgb_t HIGHLIGHT = '{red: 8'd0, green: 8'd255, blue: 8'd0};

  logic red_ok;
  logic green_ok;
  logic blue_ok;
  logic orange_hit;

  // Per-channel window tests
  assign red_ok   = video_in.rgb.red >= 8'(`ORANGE_R_MIN);
  assign green_ok = (video_in.rgb.green >= 8'(`ORANGE_G_MIN)) &&
                    (video_in.rgb.green <= 8'(`ORANGE_G_MAX));
  assign blue_ok  = video_in.rgb.blue <= 8'(`ORANGE_B_MAX);
  // Blanking beats never count as targets
  assign orange_hit = video_in.valid && red_ok && green_ok && blue_ok;

  // Single register stage, all fields move together
  always_ff @(posedge clk_50) begin
    // Pixel payload, recoloured when it is a target
    video_out.rgb <= orange_hit ? HIGHLIGHT : video_in.rgb;
    if (reset) begin
      video_out.valid <= 1'b0;
      video_out.sol   <= 1'b0;
      video_out.eof   <= 1'b0;
      is_orange       <= 1'b0;
    end else begin
      video_out.valid <= video_in.valid;
      video_out.sol   <= video_in.sol;
      video_out.eof   <= video_in.eof;
      is_orange       <= orange_hit;
    end
  end

  // Frame end marker never carries a pixel
  assert property (@(posedge clk_50) disable iff (reset)
    video_in.eof |-> !video_in.valid)
    else $error("eof beat with valid set");

endmodule

`default_nettype wire

// ==== verilog/robot_pkg.sv ====
`default_nettype none

package robot_pkg;

  // One RGB888 pixel
  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb_t;

  // One beat of the pixel stream
  // Frame end comes on its own beat with valid low
  typedef struct packed {
    rgb_t rgb;
    logic valid;  // pixel present
    logic sol;    // first valid pixel of a line
    logic eof;    // end of frame marker
  } video_beat_t;

  // Steering result from the camera
  typedef enum logic [1:0] {
    dir_left,
    dir_straight,
    dir_right
  } direction_t;

  // Wheel command to the motor stage
  typedef enum logic [2:0] {
    cmd_stop,
    cmd_forward,
    cmd_reverse,
    cmd_left,
    cmd_right
  } drive_cmd_t;

endpackage

`default_nettype wire

// ==== include/robot_settings.svh ====
`ifndef ROBOT_SETTINGS_SVH
`define ROBOT_SETTINGS_SVH

// Orange colour window on 8-bit channels
// Red must be strong, blue weak, green in a middle band
`define ORANGE_R_MIN 160
`define ORANGE_G_MIN 60
`define ORANGE_G_MAX 150
`define ORANGE_B_MAX 80

// Active pixels per line, reduced size for simulation
`define FRAME_WIDTH 48
// Smallest zone count accepted as a real target
`define ORANGE_MIN_COUNT 4

// Ultrasonic ranger timing in clk_50 cycles
`define TRIG_CYCLES 10
`define CYCLES_PER_CM 8
`define ECHO_TIMEOUT 2000
// Obstacle closer than this blocks forward motion
`define STOP_DISTANCE_CM 20

// Decoded IR remote button codes
`define IR_FWD 8'h18
`define IR_REV 8'h52
`define IR_LEFT 8'h08
`define IR_RIGHT 8'h5a
`define IR_STOP 8'h1c
`define IR_AUTO 8'h45

`endif
